/* filelist.f */
+incdir+hdl
hdl/i2c_avl_pkg.sv
hdl/i2c_avl_ctrl_if.sv
hdl/i2c_avl_ctrl.sv
hdl/i2c_avl_addr.sv
hdl/i2c_avl_wr_path.sv
hdl/i2c_avl_rd_path.sv
hdl/i2c_avl_bridge.sv
sim/i2c_avl_bridge_properties.sv
sim/i2c_avl_bridge_tb.sv

/* hdl/i2c_avl_addr.sv */
/*
 * Word-address assembler and counter
 * Shifts in the address bytes high byte first and keeps the
 * auto-incrementing master address.
 */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module i2c_avl_addr (
	input  logic                       i2c_clk,
	input  logic                       i2c_rst_n,
	input  logic [`I2C_AVL_BYTE_W-1:0] rdata_rx_databuffer,
	i2c_avl_ctrl_if.addr               ctl,
	output logic [`I2C_AVL_ADDR_W-1:0] avl_addr
);

	logic [`I2C_AVL_CNT_W-1:0] addr_asm;
	logic [`I2C_AVL_CNT_W-1:0] asm_nxt;
	logic [`I2C_AVL_CNT_W-1:0] addr_cnt;

	assign asm_nxt = {addr_asm[`I2C_AVL_CNT_W-`I2C_AVL_BYTE_W-1:0], rdata_rx_databuffer};

	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n) begin
			addr_asm <= '0;
		end else if (ctl.addr_shift) begin
			addr_asm <= asm_nxt;
		end
	end

	// wraps at the word-address width
	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n) begin
			addr_cnt <= '0;
		end else if (ctl.addr_load) begin
			addr_cnt <= ctl.addr_shift ? asm_nxt : addr_asm;
		end else if (ctl.addr_incr) begin
			addr_cnt <= addr_cnt + 1'b1;
		end
	end

	assign avl_addr = {{(`I2C_AVL_ADDR_W-`I2C_AVL_CNT_W){1'b0}}, addr_cnt};

endmodule

/* hdl/i2c_avl_bridge.sv */
/*
 * I2C slave to memory-mapped master bridge
 * Turns the received I2C byte stream into a two-byte word address and
 * 32-bit master writes, and serves master reads back to the I2C side.
 */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module i2c_avl_bridge (
	input  logic                       i2c_clk,
	input  logic                       i2c_rst_n,
	input  logic                       waitrequest,
	input  logic                       put_rx_databuffer,
	input  logic                       set_rd_req,
	input  logic                       stop_det,
	input  logic                       start_det,
	input  logic [`I2C_AVL_BYTE_W-1:0] rdata_rx_databuffer,
	input  logic [`I2C_AVL_DATA_W-1:0] avl_readdata,
	input  logic                       avl_readdatavalid,
	input  logic                       slv_tx_chk_ack,
	input  logic                       ack_det,
	output logic                       avl_read,
	output logic [`I2C_AVL_BYTE_W-1:0] readdatabyte,
	output logic                       avl_readdatavalid_reg,
	output logic                       avl_write,
	output logic [`I2C_AVL_DATA_W-1:0] avl_writedata,
	output logic [`I2C_AVL_ADDR_W-1:0] avl_addr
);

	i2c_avl_ctrl_if ctl_if (.i2c_clk(i2c_clk));

	i2c_avl_ctrl u_ctrl (
		.i2c_clk           (i2c_clk),
		.i2c_rst_n         (i2c_rst_n),
		.put_rx_databuffer (put_rx_databuffer),
		.set_rd_req        (set_rd_req),
		.stop_det          (stop_det),
		.start_det         (start_det),
		.waitrequest       (waitrequest),
		.avl_readdatavalid (avl_readdatavalid),
		.ctl               (ctl_if.ctrl)
	);

	i2c_avl_addr u_addr (
		.i2c_clk             (i2c_clk),
		.i2c_rst_n           (i2c_rst_n),
		.rdata_rx_databuffer (rdata_rx_databuffer),
		.ctl                 (ctl_if.addr),
		.avl_addr            (avl_addr)
	);

	i2c_avl_wr_path u_wr (
		.i2c_clk             (i2c_clk),
		.i2c_rst_n           (i2c_rst_n),
		.rdata_rx_databuffer (rdata_rx_databuffer),
		.ctl                 (ctl_if.wr),
		.avl_write           (avl_write),
		.avl_writedata       (avl_writedata)
	);

	i2c_avl_rd_path u_rd (
		.i2c_clk               (i2c_clk),
		.i2c_rst_n             (i2c_rst_n),
		.avl_readdata          (avl_readdata),
		.avl_readdatavalid     (avl_readdatavalid),
		.ack_det               (ack_det),
		.slv_tx_chk_ack        (slv_tx_chk_ack),
		.ctl                   (ctl_if.rd),
		.avl_read              (avl_read),
		.readdatabyte          (readdatabyte),
		.avl_readdatavalid_reg (avl_readdatavalid_reg)
	);

endmodule

/* hdl/i2c_avl_ctrl.sv */
/*
 * Bridge sequencer
 * Walks the word-address bytes, then issues one master write per data
 * byte or one master read per request or acknowledge. Stop and repeated
 * start are honoured only after a pending master access is accepted.
 */
`timescale 1ns/1ps

module i2c_avl_ctrl (
	input  logic           i2c_clk,
	input  logic           i2c_rst_n,
	input  logic           put_rx_databuffer,
	input  logic           set_rd_req,
	input  logic           stop_det,
	input  logic           start_det,
	input  logic           waitrequest,
	input  logic           avl_readdatavalid,
	i2c_avl_ctrl_if.ctrl   ctl
);

	i2c_avl_pkg::state_t state;
	i2c_avl_pkg::state_t state_nxt;
	logic                bus_evt;
	logic                evt_pend;
	logic                issuing;

	assign bus_evt = stop_det | start_det;
	assign issuing = (state == i2c_avl_pkg::ST_WR_ISSUE) || (state == i2c_avl_pkg::ST_RD_ISSUE);

	always_comb begin
		state_nxt      = state;
		ctl.addr_shift = 1'b0;
		ctl.addr_load  = 1'b0;
		ctl.addr_incr  = 1'b0;
		ctl.wr_start   = 1'b0;
		ctl.wr_done    = 1'b0;
		ctl.rd_start   = 1'b0;
		ctl.rd_done    = 1'b0;
		ctl.rd_wait    = (state == i2c_avl_pkg::ST_RD_DATA);

		case (state)
			i2c_avl_pkg::ST_IDLE: begin
				if (put_rx_databuffer) begin
					ctl.addr_shift = 1'b1;
					state_nxt      = i2c_avl_pkg::ST_ADDR_HI;
				end else if (set_rd_req) begin
					// current-address read
					ctl.rd_start = 1'b1;
					state_nxt    = i2c_avl_pkg::ST_RD_ISSUE;
				end
			end
			i2c_avl_pkg::ST_ADDR_HI: begin
				if (bus_evt) begin
					ctl.addr_load = 1'b1;
					state_nxt     = i2c_avl_pkg::ST_IDLE;
				end else if (put_rx_databuffer) begin
					// low byte goes straight through to the counter
					ctl.addr_shift = 1'b1;
					ctl.addr_load  = 1'b1;
					state_nxt      = i2c_avl_pkg::ST_ADDR_LO;
				end
			end
			i2c_avl_pkg::ST_ADDR_LO, i2c_avl_pkg::ST_WR_WAIT: begin
				if (bus_evt) begin
					ctl.addr_load = (state == i2c_avl_pkg::ST_ADDR_LO);
					state_nxt     = i2c_avl_pkg::ST_IDLE;
				end else if (put_rx_databuffer) begin
					ctl.wr_start = 1'b1;
					state_nxt    = i2c_avl_pkg::ST_WR_ISSUE;
				end
			end
			i2c_avl_pkg::ST_WR_ISSUE: begin
				if (!waitrequest) begin
					ctl.wr_done   = 1'b1;
					ctl.addr_incr = 1'b1;
					state_nxt     = (bus_evt || evt_pend) ? i2c_avl_pkg::ST_IDLE :
					                                        i2c_avl_pkg::ST_WR_WAIT;
				end
			end
			i2c_avl_pkg::ST_RD_ISSUE: begin
				if (!waitrequest) begin
					ctl.rd_done = 1'b1;
					state_nxt   = (bus_evt || evt_pend) ? i2c_avl_pkg::ST_IDLE :
					                                      i2c_avl_pkg::ST_RD_DATA;
				end
			end
			i2c_avl_pkg::ST_RD_DATA: begin
				// address moves on once the read word is back
				ctl.addr_incr = avl_readdatavalid;
				if (bus_evt) begin
					state_nxt = i2c_avl_pkg::ST_IDLE;
				end else if (ctl.ack_next) begin
					ctl.rd_start = 1'b1;
					state_nxt    = i2c_avl_pkg::ST_RD_ISSUE;
				end
			end
			default: begin
				state_nxt = i2c_avl_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n) begin
			state    <= i2c_avl_pkg::ST_IDLE;
			evt_pend <= 1'b0;
		end else begin
			state <= state_nxt;
			// remember a stop seen while the master port is still busy
			evt_pend <= issuing && (state_nxt == state) && (evt_pend || bus_evt);
		end
	end

endmodule

/* hdl/i2c_avl_ctrl_if.sv */
/*
 * Bridge control strobes
 * Carries one-cycle strobes from the sequencer to the address, write and
 * read datapaths, and the acknowledge event back from the read path.
 */
`timescale 1ns/1ps

interface i2c_avl_ctrl_if (
	input logic i2c_clk
);

	logic addr_shift;
	logic addr_load;
	logic addr_incr;
	logic wr_start;
	logic wr_done;
	logic rd_start;
	logic rd_done;
	logic rd_wait;
	logic ack_next;

	modport ctrl (
		input  i2c_clk, ack_next,
		output addr_shift, addr_load, addr_incr, wr_start, wr_done,
		output rd_start, rd_done, rd_wait
	);
	modport addr (input i2c_clk, addr_shift, addr_load, addr_incr);
	modport wr (input i2c_clk, wr_start, wr_done);
	modport rd (input i2c_clk, rd_start, rd_done, rd_wait, output ack_next);

endinterface

/* hdl/i2c_avl_defs.svh */
/*
 * I2C to memory-mapped bridge widths
 * Byte, data, address and word-address counter sizes shared by the
 * bridge datapaths.
 */
`ifndef I2C_AVL_DEFS_SVH
`define I2C_AVL_DEFS_SVH

// serial byte as delivered by the I2C slave
`define I2C_AVL_BYTE_W 8

// master port
`define I2C_AVL_DATA_W 32
`define I2C_AVL_ADDR_W 32

// word address is sent high byte first
`define I2C_AVL_ADDR_BYTES 2
`define I2C_AVL_CNT_W (`I2C_AVL_ADDR_BYTES * `I2C_AVL_BYTE_W)

`endif

/* hdl/i2c_avl_pkg.sv */
/*
 * I2C to memory-mapped bridge package
 * Control state encoding of the bridge sequencer.
 */
package i2c_avl_pkg;

	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_ADDR_HI  = 3'd1,
		ST_ADDR_LO  = 3'd2,
		ST_WR_WAIT  = 3'd3,
		ST_WR_ISSUE = 3'd4,
		ST_RD_ISSUE = 3'd5,
		ST_RD_DATA  = 3'd6
	} state_t;

endpackage

/* hdl/i2c_avl_rd_path.sv */
/*
 * Read datapath
 * Holds the master read request, captures the low byte of the returned
 * word and flags a new acknowledge from the I2C master.
 */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module i2c_avl_rd_path (
	input  logic                       i2c_clk,
	input  logic                       i2c_rst_n,
	input  logic [`I2C_AVL_DATA_W-1:0] avl_readdata,
	input  logic                       avl_readdatavalid,
	input  logic                       ack_det,
	input  logic                       slv_tx_chk_ack,
	i2c_avl_ctrl_if.rd                 ctl,
	output logic                       avl_read,
	output logic [`I2C_AVL_BYTE_W-1:0] readdatabyte,
	output logic                       avl_readdatavalid_reg
);

	logic ack_det_reg;

	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n) begin
			avl_read              <= 1'b0;
			readdatabyte          <= '0;
			avl_readdatavalid_reg <= 1'b0;
			ack_det_reg           <= 1'b0;
		end else begin
			if (ctl.rd_start)
				avl_read <= 1'b1;
			else if (ctl.rd_done)
				avl_read <= 1'b0;
			if (ctl.rd_wait && avl_readdatavalid)
				readdatabyte <= avl_readdata[`I2C_AVL_BYTE_W-1:0];
			avl_readdatavalid_reg <= avl_readdatavalid;
			ack_det_reg           <= ack_det;
		end
	end

	// rising ack while the slave transmitter waits for it
	assign ctl.ack_next = slv_tx_chk_ack & ack_det & ~ack_det_reg;

endmodule

/* hdl/i2c_avl_wr_path.sv */
/*
 * Write datapath
 * Holds the zero-extended data byte and the master write request.
 */
`timescale 1ns/1ps
`include "i2c_avl_defs.svh"

module i2c_avl_wr_path (
	input  logic                       i2c_clk,
	input  logic                       i2c_rst_n,
	input  logic [`I2C_AVL_BYTE_W-1:0] rdata_rx_databuffer,
	i2c_avl_ctrl_if.wr                 ctl,
	output logic                       avl_write,
	output logic [`I2C_AVL_DATA_W-1:0] avl_writedata
);

	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n) begin
			avl_write <= 1'b0;
		end else if (ctl.wr_start) begin
			avl_write <= 1'b1;
		end else if (ctl.wr_done) begin
			avl_write <= 1'b0;
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (ctl.wr_start) begin
			avl_writedata <= {{(`I2C_AVL_DATA_W-`I2C_AVL_BYTE_W){1'b0}}, rdata_rx_databuffer};
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# builds the bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f filelist.f --top-module i2c_avl_bridge_tb -o i2c_avl_bridge_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/i2c_avl_bridge_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1

/* sim/i2c_avl_bridge_properties.sv */
/*
 * Master port rules for the I2C bridge
 * Bound into the bridge top level. Checks request exclusivity, request
 * hold under waitrequest and the read-valid pulse.
 */
`timescale 1ns/1ps

module i2c_avl_bridge_properties (
	input logic i2c_clk,
	input logic i2c_rst_n,
	input logic avl_read,
	input logic avl_write,
	input logic waitrequest,
	input logic avl_readdatavalid_reg
);

	no_dual_request: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		!(avl_read && avl_write))
		else $error("avl_read and avl_write high together");

	read_hold: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		(avl_read && waitrequest) |=> avl_read)
		else $error("avl_read dropped while waitrequest was high");

	write_hold: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		(avl_write && waitrequest) |=> avl_write)
		else $error("avl_write dropped while waitrequest was high");

	valid_pulse: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		avl_readdatavalid_reg |=> !avl_readdatavalid_reg)
		else $error("avl_readdatavalid_reg longer than one cycle");

endmodule

bind i2c_avl_bridge i2c_avl_bridge_properties props (
	.i2c_clk               (i2c_clk),
	.i2c_rst_n             (i2c_rst_n),
	.avl_read              (avl_read),
	.avl_write             (avl_write),
	.waitrequest           (waitrequest),
	.avl_readdatavalid_reg (avl_readdatavalid_reg)
);

/* sim/i2c_avl_bridge_tb.sv */
/*
 * I2C to memory-mapped bridge testbench
 * Runs a table of address, write and read sequences against the bridge,
 * with a 256-word memory slave that stalls the master port at random.
 */
`timescale 1ns/1ps

module i2c_avl_bridge_tb;

	localparam int N_OPS   = 8;
	localparam int RST_CYC = 10;
	localparam int LIMIT   = N_OPS * 200 + RST_CYC;

	localparam logic [1:0] OP_WRITE = 2'd0;
	localparam logic [1:0] OP_ADDR  = 2'd1;
	localparam logic [1:0] OP_READ  = 2'd2;

	typedef struct packed {
		logic [1:0]  kind;
		logic [15:0] addr;
		logic [7:0]  cnt;
		logic [7:0]  data;
	} op_t;

	// kind, word address (expected start for reads), byte count, first data byte
	localparam op_t OPS [N_OPS] = '{
		{OP_WRITE, 16'h0010, 8'd4, 8'h11},
		{OP_ADDR,  16'h0011, 8'd0, 8'h00},
		{OP_READ,  16'h0011, 8'd3, 8'h00},
		{OP_WRITE, 16'hfffe, 8'd4, 8'ha0},
		{OP_ADDR,  16'hffff, 8'd0, 8'h00},
		{OP_READ,  16'hffff, 8'd3, 8'h00},
		{OP_ADDR,  16'h0080, 8'd0, 8'h00},
		{OP_READ,  16'h0080, 8'd2, 8'h00}
	};

	logic        i2c_clk;
	logic        i2c_rst_n;
	logic        put_rx_databuffer;
	logic        set_rd_req;
	logic        stop_det;
	logic        start_det;
	logic [7:0]  rdata_rx_databuffer;
	logic        slv_tx_chk_ack;
	logic        ack_det;
	logic        waitrequest = 1'b1;
	logic [31:0] avl_readdata = '0;
	logic        avl_readdatavalid = 1'b0;
	logic        avl_read;
	logic [7:0]  readdatabyte;
	logic        avl_readdatavalid_reg;
	logic        avl_write;
	logic [31:0] avl_writedata;
	logic [31:0] avl_addr;

	logic [31:0] mem [256];
	logic [31:0] ref_mem [256];
	logic [31:0] rnd = 32'h041314e7;
	logic [1:0]  rd_pipe;
	logic [7:0]  rd_idx;
	logic [31:0] wr_seen_addr [$];
	logic [31:0] wr_seen_data [$];
	logic [31:0] rd_seen_addr [$];
	int          errors;
	int          n_pass;
	int          n_fail;
	int          cycles;

	i2c_avl_bridge uut (.*);

	initial begin
		i2c_clk = 1'b0;
		forever #5 i2c_clk = ~i2c_clk;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return {8'hc3, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
	endfunction

	// memory slave: random stall, read data two cycles after acceptance
	always @(posedge i2c_clk) begin
		rnd         <= next_rand(rnd);
		waitrequest <= rnd[0];
		if (!i2c_rst_n) begin
			rd_pipe           <= 2'b00;
			avl_readdatavalid <= 1'b0;
			for (int i = 0; i < 256; i++)
				mem[i] <= fill_word(i);
		end else begin
			rd_pipe           <= {rd_pipe[0], 1'b0};
			avl_readdatavalid <= rd_pipe[1];
			if (rd_pipe[1])
				avl_readdata <= mem[rd_idx];
			if (avl_write && !waitrequest) begin
				mem[avl_addr[7:0]] <= avl_writedata;
				wr_seen_addr.push_back(avl_addr);
				wr_seen_data.push_back(avl_writedata);
			end
			if (avl_read && !waitrequest) begin
				rd_pipe[0] <= 1'b1;
				rd_idx     <= avl_addr[7:0];
				rd_seen_addr.push_back(avl_addr);
			end
		end
	end

	always @(posedge i2c_clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0) begin
			n_pass++;
			$display("test %s passed", name);
		end else begin
			n_fail++;
			$display("test %s failed with %0d errors", name, errors - err0);
		end
	endtask

	task automatic put_byte(input logic [7:0] b);
		@(posedge i2c_clk);
		rdata_rx_databuffer <= b;
		put_rx_databuffer   <= 1'b1;
		@(posedge i2c_clk);
		put_rx_databuffer   <= 1'b0;
	endtask

	task automatic send_stop();
		@(posedge i2c_clk);
		stop_det <= 1'b1;
		@(posedge i2c_clk);
		stop_det <= 1'b0;
	endtask

	// first byte by read request, later bytes by acknowledge edge
	task automatic request_read(input logic first);
		@(posedge i2c_clk);
		if (first)
			set_rd_req <= 1'b1;
		else
			ack_det <= 1'b1;
		@(posedge i2c_clk);
		set_rd_req <= 1'b0;
		ack_det    <= 1'b0;
	endtask

	task automatic run_write(input op_t op);
		logic [15:0] a;
		logic [7:0]  d;
		put_byte(op.addr[15:8]);
		put_byte(op.addr[7:0]);
		for (int k = 0; k < int'(op.cnt); k++) begin
			a = op.addr + 16'(k);
			d = op.data + 8'(k);
			put_byte(d);
			@(negedge i2c_clk);
			while (wr_seen_addr.size() == 0)
				@(negedge i2c_clk);
			check("avl_addr", wr_seen_addr.pop_front(), {16'h0, a});
			check("avl_writedata", wr_seen_data.pop_front(), {24'h0, d});
			ref_mem[a[7:0]] = {24'h0, d};
		end
		send_stop();
	endtask

	task automatic run_addr(input op_t op);
		put_byte(op.addr[15:8]);
		put_byte(op.addr[7:0]);
		send_stop();
		@(negedge i2c_clk);
		check("avl_addr", avl_addr, {16'h0, op.addr});
	endtask

	task automatic run_read(input op_t op);
		logic [15:0] a;
		@(posedge i2c_clk);
		slv_tx_chk_ack <= 1'b1;
		for (int k = 0; k < int'(op.cnt); k++) begin
			a = op.addr + 16'(k);
			request_read(k == 0);
			@(negedge i2c_clk);
			while (!avl_readdatavalid_reg)
				@(negedge i2c_clk);
			check("readdatabyte", {24'h0, readdatabyte}, {24'h0, ref_mem[a[7:0]][7:0]});
			check("slave read count", rd_seen_addr.size(), 1);
			if (rd_seen_addr.size() != 0)
				check("avl_addr", rd_seen_addr.pop_front(), {16'h0, a});
		end
		send_stop();
		// an acknowledge after the stop must not start another read
		request_read(1'b0);
		slv_tx_chk_ack <= 1'b0;
	endtask

	initial begin
		int err0;
		i2c_rst_n           <= 1'b0;
		put_rx_databuffer   <= 1'b0;
		set_rd_req          <= 1'b0;
		stop_det            <= 1'b0;
		start_det           <= 1'b0;
		rdata_rx_databuffer <= 8'h00;
		slv_tx_chk_ack      <= 1'b0;
		ack_det             <= 1'b0;
		for (int i = 0; i < 256; i++)
			ref_mem[i] = fill_word(i);
		repeat (RST_CYC) @(posedge i2c_clk);
		i2c_rst_n <= 1'b1;
		@(negedge i2c_clk);
		err0 = errors;
		check("avl_read", {31'h0, avl_read}, 32'h0);
		check("avl_write", {31'h0, avl_write}, 32'h0);
		check("avl_readdatavalid_reg", {31'h0, avl_readdatavalid_reg}, 32'h0);
		check("readdatabyte", {24'h0, readdatabyte}, 32'h0);
		check("avl_addr", avl_addr, 32'h0);
		report_test("reset", err0);

		for (int t = 0; t < N_OPS; t++) begin
			err0 = errors;
			case (OPS[t].kind)
				OP_WRITE: run_write(OPS[t]);
				OP_ADDR:  run_addr(OPS[t]);
				default:  run_read(OPS[t]);
			endcase
			// nothing more may reach the slave once the sequence is stopped
			repeat (4) @(negedge i2c_clk);
			check("avl_read", {31'h0, avl_read}, 32'h0);
			check("avl_write", {31'h0, avl_write}, 32'h0);
			check("slave write count", wr_seen_addr.size(), 0);
			check("slave read count", rd_seen_addr.size(), 0);
			for (int i = 0; i < 256; i++)
				check($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
			report_test($sformatf("op %0d", t), err0);
		end

		$display("%0d tests passed, %0d failed, %0d errors", n_pass, n_fail, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
